// ==== execute_stage.sv ====
module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 dx_valid,
    input  rv_pkg::instr_class_t dx_class,
    input  rv_pkg::alu_op_t      dx_op,
    input  rv_pkg::reg_idx_t     dx_rs1,
    input  rv_pkg::reg_idx_t     dx_rs2,
    input  rv_pkg::reg_idx_t     dx_rd,
    input  rv_pkg::word_t        dx_rs1_val,
    input  rv_pkg::word_t        dx_rs2_val,
    input  rv_pkg::word_t        dx_imm,
    input  logic                 wb_en,
    input  rv_pkg::reg_idx_t     wb_rd,
    input  rv_pkg::word_t        wb_data,
    output logic                 xm_valid,
    output rv_pkg::instr_class_t xm_class,
    output rv_pkg::reg_idx_t     xm_rd,
    output rv_pkg::word_t        xm_result,
    output rv_pkg::word_t        xm_store_data
);
    import rv_pkg::*;

    logic       xm_fwd;
    logic       wb_fwd;
    word_t      op_a;
    word_t      rs2_fwd;
    word_t      op_b;
    word_t      alu_out;
    logic [4:0] shamt;

    assign xm_fwd = xm_valid && writes_reg(xm_class) && (xm_rd != '0);
    assign wb_fwd = wb_en && (wb_rd != '0);

    // youngest producer wins
    always_comb begin
        if (xm_fwd && (xm_rd == dx_rs1)) begin
            op_a = xm_result;
        end else if (wb_fwd && (wb_rd == dx_rs1)) begin
            op_a = wb_data;
        end else begin
            op_a = dx_rs1_val;
        end

        if (xm_fwd && (xm_rd == dx_rs2)) begin
            rs2_fwd = xm_result;
        end else if (wb_fwd && (wb_rd == dx_rs2)) begin
            rs2_fwd = wb_data;
        end else begin
            rs2_fwd = dx_rs2_val;
        end
    end

    assign op_b  = (dx_class == alu_imm || dx_class == store) ? dx_imm : rs2_fwd;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dx_op)
            op_add:  alu_out = op_a + op_b;
            op_sub:  alu_out = op_a - op_b;
            op_and:  alu_out = op_a & op_b;
            op_or:   alu_out = op_a | op_b;
            op_xor:  alu_out = op_a ^ op_b;
            op_sll:  alu_out = op_a << shamt;
            op_srl:  alu_out = op_a >> shamt;
            op_sra:  alu_out = $signed(op_a) >>> shamt;
            default: alu_out = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xm_valid      <= 1'b0;
            xm_class      <= bubble;
            xm_rd         <= '0;
            xm_result     <= '0;
            xm_store_data <= '0;
        end else if (!stall) begin
            xm_valid      <= dx_valid;
            xm_class      <= dx_class;
            xm_rd         <= dx_rd;
            xm_result     <= alu_out;
            xm_store_data <= rs2_fwd; // sw data, forwarded
        end
    end

endmodule

// ==== instr_decode.sv ====
`include "rv_params.svh"

module instr_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  rv_pkg::word_t        instr,
    input  logic                 stall,
    output rv_pkg::reg_idx_t     rs1,
    output rv_pkg::reg_idx_t     rs2,
    input  rv_pkg::word_t        rs1_val,
    input  rv_pkg::word_t        rs2_val,
    output logic                 dx_valid,
    output rv_pkg::instr_class_t dx_class,
    output rv_pkg::alu_op_t      dx_op,
    output rv_pkg::reg_idx_t     dx_rs1,
    output rv_pkg::reg_idx_t     dx_rs2,
    output rv_pkg::reg_idx_t     dx_rd,
    output rv_pkg::word_t        dx_rs1_val,
    output rv_pkg::word_t        dx_rs2_val,
    output rv_pkg::word_t        dx_imm
);
    import rv_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   funct3;
    logic         f3_alu_ok;
    logic         take;
    instr_class_t cls;
    alu_op_t      op;
    reg_idx_t     rd;
    word_t        imm;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign f3_alu_ok = (funct3 != 3'b010) && (funct3 != 3'b011); // no slt/sltu

    assign instr_ready = !stall;
    assign take        = instr_valid && instr_ready;

    always_comb begin
        case (opcode)
            `OPC_RTYPE: cls = f3_alu_ok ? alu_reg : bubble;
            `OPC_ITYPE: cls = f3_alu_ok ? alu_imm : bubble;
            `OPC_STORE: cls = (funct3 == `F3_SW) ? store : bubble;
            default:    cls = bubble;
        endcase
    end

    // unused index fields stay zero
    always_comb begin
        rs1 = '0;
        rs2 = '0;
        rd  = '0;
        imm = '0;
        case (cls)
            alu_reg: begin
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                rd  = instr[11:7];
            end
            alu_imm: begin
                rs1 = instr[19:15];
                rd  = instr[11:7];
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            store: begin
                rs1 = instr[19:15];
                rs2 = instr[24:20];
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // s-type split imm
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (funct3)
            `F3_ADD_SUB: op = (cls == alu_reg && instr[30]) ? op_sub : op_add;
            `F3_SLL:     op = op_sll;
            `F3_XOR:     op = op_xor;
            `F3_SRL_SRA: op = instr[30] ? op_sra : op_srl; // same bit for srai
            `F3_OR:      op = op_or;
            `F3_AND:     op = op_and;
            default:     op = op_add;
        endcase
        if (cls == store) begin
            op = op_add; // address = rs1 + imm
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dx_valid   <= 1'b0;
            dx_class   <= bubble;
            dx_op      <= op_add;
            dx_rs1     <= '0;
            dx_rs2     <= '0;
            dx_rd      <= '0;
            dx_rs1_val <= '0;
            dx_rs2_val <= '0;
            dx_imm     <= '0;
        end else if (!stall) begin
            dx_valid   <= take && (cls != bubble);
            dx_class   <= take ? cls : bubble;
            dx_op      <= op;
            dx_rs1     <= rs1;
            dx_rs2     <= rs2;
            dx_rd      <= rd;
            dx_rs1_val <= rs1_val;
            dx_rs2_val <= rs2_val;
            dx_imm     <= imm;
        end
    end

endmodule

// ==== mem_stage.sv ====
`include "rv_params.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 xm_valid,
    input  rv_pkg::instr_class_t xm_class,
    input  rv_pkg::reg_idx_t     xm_rd,
    input  rv_pkg::word_t        xm_result,
    input  rv_pkg::word_t        xm_store_data,
    output logic                 store_valid,
    input  logic                 store_ready,
    output logic [`XLEN-3:0]     store_addr,
    output rv_pkg::word_t        store_data,
    output logic                 stall,
    output logic                 wb_en,
    output rv_pkg::reg_idx_t     wb_rd,
    output rv_pkg::word_t        wb_data
);
    import rv_pkg::*;

    assign store_valid = xm_valid && (xm_class == store);
    assign store_addr  = xm_result[`XLEN-1:2]; // word address
    assign store_data  = xm_store_data;

    // a waiting store freezes every stage, xm included, so the port stays stable
    assign stall = store_valid && !store_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end else if (!stall) begin
            wb_en   <= xm_valid && writes_reg(xm_class);
            wb_rd   <= xm_rd;
            wb_data <= xm_result;
        end
    end

endmodule

// ==== reg_file.sv ====
`include "rv_params.svh"

module reg_file (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val,
    input  logic             wr_en,
    input  rv_pkg::reg_idx_t wr_idx,
    input  rv_pkg::word_t    wr_data
);
    import rv_pkg::*;

    word_t regs [`REG_COUNT];
    logic  wr_live;

    assign wr_live = wr_en && (wr_idx != '0); // x0 never written

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through so decode sees a value retiring this cycle
    always_comb begin
        if (wr_live && (wr_idx == rs1)) begin
            rs1_val = wr_data;
        end else begin
            rs1_val = regs[rs1];
        end
        if (wr_live && (wr_idx == rs2)) begin
            rs2_val = wr_data;
        end else begin
            rs2_val = regs[rs2];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, pass is decided from the log
rm -f sim.log
verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

// ==== rv_core.f ====
+incdir+.
rv_pkg.sv
reg_file.sv
instr_decode.sv
execute_stage.sv
mem_stage.sv
rv_core.sv
rv_core_tb.sv

// ==== rv_core.sv ====
`include "rv_params.svh"

module rv_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  rv_pkg::word_t    instr,
    output logic             store_valid,
    input  logic             store_ready,
    output logic [`XLEN-3:0] store_addr,
    output rv_pkg::word_t    store_data
);
    import rv_pkg::*;

    logic         stall;

    reg_idx_t     rf_rs1;
    reg_idx_t     rf_rs2;
    word_t        rf_rs1_val;
    word_t        rf_rs2_val;

    logic         dx_valid;
    instr_class_t dx_class;
    alu_op_t      dx_op;
    reg_idx_t     dx_rs1;
    reg_idx_t     dx_rs2;
    reg_idx_t     dx_rd;
    word_t        dx_rs1_val;
    word_t        dx_rs2_val;
    word_t        dx_imm;

    logic         xm_valid;
    instr_class_t xm_class;
    reg_idx_t     xm_rd;
    word_t        xm_result;
    word_t        xm_store_data;

    logic         wb_en;
    reg_idx_t     wb_rd;
    word_t        wb_data;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (rf_rs1),
        .rs2     (rf_rs2),
        .rs1_val (rf_rs1_val),
        .rs2_val (rf_rs2_val),
        .wr_en   (wb_en),
        .wr_idx  (wb_rd),
        .wr_data (wb_data)
    );

    instr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .stall       (stall),
        .rs1         (rf_rs1),
        .rs2         (rf_rs2),
        .rs1_val     (rf_rs1_val),
        .rs2_val     (rf_rs2_val),
        .dx_valid    (dx_valid),
        .dx_class    (dx_class),
        .dx_op       (dx_op),
        .dx_rs1      (dx_rs1),
        .dx_rs2      (dx_rs2),
        .dx_rd       (dx_rd),
        .dx_rs1_val  (dx_rs1_val),
        .dx_rs2_val  (dx_rs2_val),
        .dx_imm      (dx_imm)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .dx_valid      (dx_valid),
        .dx_class      (dx_class),
        .dx_op         (dx_op),
        .dx_rs1        (dx_rs1),
        .dx_rs2        (dx_rs2),
        .dx_rd         (dx_rd),
        .dx_rs1_val    (dx_rs1_val),
        .dx_rs2_val    (dx_rs2_val),
        .dx_imm        (dx_imm),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .xm_valid      (xm_valid),
        .xm_class      (xm_class),
        .xm_rd         (xm_rd),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data)
    );

    mem_stage u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .xm_valid      (xm_valid),
        .xm_class      (xm_class),
        .xm_rd         (xm_rd),
        .xm_result     (xm_result),
        .xm_store_data (xm_store_data),
        .store_valid   (store_valid),
        .store_ready   (store_ready),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .stall         (stall),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

// ==== rv_core_tb.sv ====
`include "rv_params.svh"

module rv_core_tb;
    import rv_pkg::*;

    logic             clk;
    logic             rst_n;
    logic             instr_valid;
    logic             instr_ready;
    word_t            instr;
    logic             store_valid;
    logic             store_ready;
    logic [`XLEN-3:0] store_addr;
    word_t            store_data;

    integer seed = 32'h50de8b4b;
    word_t  ref_regs [`REG_COUNT];
    word_t  exp_addr_q [$];
    word_t  exp_data_q [$];
    string  cur_test;
    int     errors;
    int     tests_run;
    int     tests_failed;
    logic   bp_on;

    rv_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_val(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("mismatch test=%s expected=%h actual=%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_timeout(string what);
        $display("timeout in test %s while waiting for %s", cur_test, what);
        $display("Simulation failed");
        $finish;
    endtask

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // reference execution in program order
    task automatic model_exec(word_t w);
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        f3 = w[14:12];
        a  = ref_regs[w[19:15]];
        if (w[6:0] == `OPC_RTYPE && f3 != 3'b010 && f3 != 3'b011) begin
            b = ref_regs[w[24:20]];
            if (w[11:7] != 5'd0) ref_regs[w[11:7]] = alu_ref(f3, w[30], a, b);
        end else if (w[6:0] == `OPC_ITYPE && f3 != 3'b010 && f3 != 3'b011) begin
            b = {{20{w[31]}}, w[31:20]};
            if (w[11:7] != 5'd0) ref_regs[w[11:7]] = alu_ref(f3, w[30] && f3 == 3'b101, a, b);
        end else if (w[6:0] == `OPC_STORE && f3 == 3'b010) begin
            b = a + {{20{w[31]}}, w[31:25], w[11:7]};
            exp_addr_q.push_back({2'b00, b[31:2]});
            exp_data_q.push_back(ref_regs[w[24:20]]);
        end
    endtask

    function automatic word_t rand_alu(logic imm_form, int lo, int hi);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        case (rand_range(0, 5))
            0:       f3 = 3'b000;
            1:       f3 = 3'b001;
            2:       f3 = 3'b100;
            3:       f3 = 3'b101;
            4:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        alt = ((f3 == 3'b000 && !imm_form) || f3 == 3'b101) ? 1'($random(seed)) : 1'b0;
        rd  = 5'(rand_range(lo, hi));
        rs1 = 5'(rand_range(lo, hi));
        rs2 = 5'(rand_range(lo, hi));
        if (!imm_form) return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_RTYPE};
        if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt, 5'b0, 5'($random(seed))};
        else imm = 12'($random(seed));
        return {imm, rs1, f3, rd, `OPC_ITYPE};
    endfunction

    function automatic word_t rand_store(int lo, int hi);
        logic [11:0] imm;
        imm = 12'($random(seed));
        return {imm[11:5], 5'(rand_range(lo, hi)), 5'(rand_range(lo, hi)), 3'b010,
                imm[4:0], `OPC_STORE};
    endfunction

    // caller sits just after a falling edge
    task automatic send_instr(word_t w);
        int t;
        t = 0;
        instr_valid = 1'b1;
        instr       = w;
        #1;
        while (!instr_ready) begin
            @(negedge clk);
            #1;
            t++;
            if (t > 200) abort_timeout("instr_ready");
        end
        model_exec(w);
        @(negedge clk);
    endtask

    task automatic idle(int n);
        instr_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain_stores();
        int t;
        t = 0;
        idle(1);
        while (exp_data_q.size() > 0) begin
            @(negedge clk);
            t++;
            if (t > 500) abort_timeout("expected stores");
        end
        idle(3);
    endtask

    task automatic run_mix(int n, int kind, int lo, int hi, logic gaps);
        logic imm_form;
        for (int i = 0; i < n; i++) begin
            imm_form = (kind == 2) ? 1'($random(seed)) : (kind == 1);
            if (gaps && rand_range(0, 3) == 0) idle(rand_range(1, 2));
            if (rand_range(0, 3) == 0) send_instr(rand_store(lo, hi));
            else send_instr(rand_alu(imm_form, lo, hi));
        end
        drain_stores();
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: FAILED with %0d errors", cur_test, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    // handshakes observed between edges, completed at the next rising edge
    initial begin
        forever begin
            @(negedge clk);
            #2;
            if (rst_n && store_valid && store_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("test %s: a store appeared that the program never issued",
                             cur_test);
                    errors++;
                end else begin
                    check_val({cur_test, ".addr"}, exp_addr_q.pop_front(), {2'b00, store_addr});
                    check_val({cur_test, ".data"}, exp_data_q.pop_front(), store_data);
                end
            end
        end
    end

    always @(negedge clk) begin
        store_ready <= bp_on ? 1'($random(seed)) : 1'b1;
    end

    initial begin
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        store_ready  = 1'b1;
        bp_on        = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset";
        for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            #1;
            check_val("reset.store_valid", 32'd0, {31'd0, store_valid});
            check_val("reset.instr_ready", 32'd1, {31'd0, instr_ready});
        end
        finish_test();

        cur_test = "rtype";
        for (int i = 1; i < `REG_COUNT; i++) send_instr({12'($random(seed)), 5'd0, 3'b000,
                                                         5'(i), `OPC_ITYPE});
        run_mix(300, 0, 0, 31, 1'b0);
        finish_test();

        cur_test = "itype";
        run_mix(300, 1, 0, 31, 1'b0);
        finish_test();

        cur_test = "dependencies";
        run_mix(400, 2, 1, 3, 1'b0);
        finish_test();

        cur_test = "backpressure";
        bp_on = 1'b1;
        run_mix(400, 2, 1, 6, 1'b1);
        bp_on = 1'b0;
        finish_test();

        cur_test = "x0_bubbles";
        for (int i = 0; i < 60; i++) begin
            case (rand_range(0, 3))
                0: send_instr({12'($random(seed)), 5'(rand_range(0, 31)), 3'b000, 5'd0,
                               `OPC_ITYPE});
                1: send_instr({25'($random(seed)), 7'b0000011});
                2: send_instr({25'($random(seed)), 7'b1100011});
                default: send_instr({7'($random(seed)), 5'd0, 5'd0, 3'b010, 5'd0,
                                     `OPC_STORE} | (rand_range(0, 1) << 20));
            endcase
        end
        for (int i = 0; i < `REG_COUNT; i++) send_instr({7'd0, 5'(i), 5'd0, 3'b010, 5'd0,
                                                         `OPC_STORE});
        drain_stores();
        finish_test();

        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define XLEN       32
`define REG_COUNT  32
`define REG_IDX_W  5

// accepted opcodes
`define OPC_RTYPE  7'b0110011
`define OPC_ITYPE  7'b0010011
`define OPC_STORE  7'b0100011

// funct3 encodings
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SW      3'b010
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

`endif

// ==== rv_pkg.sv ====
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_srl = 3'd6,
        op_sra = 3'd7
    } alu_op_t;

    // bubble is zero so a cleared register reads as empty
    typedef enum logic [1:0] {
        bubble  = 2'd0,
        alu_reg = 2'd1,
        alu_imm = 2'd2,
        store   = 2'd3
    } instr_class_t;

    // classes that end in a register write
    function automatic logic writes_reg(instr_class_t cls);
        return (cls == alu_reg) || (cls == alu_imm);
    endfunction

endpackage
